//--- source/prefix_pkg.sv
`default_nettype none

package prefix_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int PACKET_W  = 128;  // Fetch window, byte 0 in the top bits
    localparam int BYTE_W    = 8;
    localparam int NUM_SLOTS = 3;    // Leading bytes checked for prefixes
    localparam int SEG_W     = 6;    // One bit per segment register

    // Bit positions inside the segment one-hot
    localparam int SEG_ES = 0;
    localparam int SEG_CS = 1;
    localparam int SEG_SS = 2;
    localparam int SEG_DS = 3;
    localparam int SEG_FS = 4;
    localparam int SEG_GS = 5;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [SEG_W-1:0]  seg_onehot_t;    // All zeros means no override
    typedef logic [1:0]        prefix_count_t;  // 0 to NUM_SLOTS

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Prefix byte codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam byte_t PFX_REPNE  = 8'hF2;
    localparam byte_t PFX_REP    = 8'hF3;
    localparam byte_t PFX_OPSIZE = 8'h66;  // Operand-size override

    // Segment overrides
    localparam byte_t PFX_ES = 8'h26;
    localparam byte_t PFX_CS = 8'h2E;
    localparam byte_t PFX_SS = 8'h36;
    localparam byte_t PFX_DS = 8'h3E;
    localparam byte_t PFX_FS = 8'h64;
    localparam byte_t PFX_GS = 8'h65;

endpackage

`default_nettype wire

//--- source/prefix_info_if.sv
`timescale 1ns/1ns
`default_nettype none

// Registered lookup result of one prefix slot
interface prefix_info_if import prefix_pkg::*; ();

    byte_t       raw_byte;   // Byte as fetched, used when it is the opcode
    logic        is_prefix;  // Byte is one of the known prefix codes
    logic        is_rep;
    logic        is_repne;
    seg_onehot_t seg;        // Segment override carried by this byte
    logic        is_opsize;

    modport producer (
        output raw_byte, is_prefix, is_rep, is_repne, seg, is_opsize
    );

    modport consumer (
        input raw_byte, is_prefix, is_rep, is_repne, seg, is_opsize
    );

endinterface

`default_nettype wire

//--- source/window_capture.sv
`timescale 1ns/1ns
`default_nettype none

module window_capture import prefix_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic [PACKET_W-1:0] packet,
    input  wire logic                packet_valid,
    output byte_t                    slot_byte [NUM_SLOTS],
    output byte_t                    tail_byte,
    output logic                     stage_valid
);

    localparam int TAIL_MSB = PACKET_W - 1 - NUM_SLOTS * BYTE_W;  // Byte after the slots

    byte_t tail_q;   // First stage copy of the tail byte
    logic  valid_q;  // First stage copy of the strobe

    // Only the leading bytes are kept, the rest of the window is not decoded here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slot_byte[i] <= '0;
            end
            tail_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slot_byte[i] <= packet[PACKET_W - 1 - i * BYTE_W -: BYTE_W];  // MSB first
            end
            tail_q  <= packet[TAIL_MSB -: BYTE_W];
            valid_q <= packet_valid;
        end
    end

    // Second stage keeps pace with the lookup tables
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail_byte   <= '0;
            stage_valid <= 1'b0;
        end else begin
            tail_byte   <= tail_q;
            stage_valid <= valid_q;
        end
    end

endmodule

`default_nettype wire

//--- source/prefix_lut.sv
`timescale 1ns/1ns
`default_nettype none

module prefix_lut import prefix_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire byte_t      prefix,
    prefix_info_if.producer info
);

    logic        pfx_c;
    logic        rep_c;
    logic        repne_c;
    logic        opsize_c;
    seg_onehot_t seg_c;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte classification
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        pfx_c    = 1'b1;  // Cleared again by the default branch
        rep_c    = 1'b0;
        repne_c  = 1'b0;
        opsize_c = 1'b0;
        seg_c    = '0;
        case (prefix)
            PFX_REPNE:  repne_c  = 1'b1;
            PFX_REP:    rep_c    = 1'b1;
            PFX_OPSIZE: opsize_c = 1'b1;
            PFX_ES:     seg_c[SEG_ES] = 1'b1;
            PFX_CS:     seg_c[SEG_CS] = 1'b1;
            PFX_SS:     seg_c[SEG_SS] = 1'b1;
            PFX_DS:     seg_c[SEG_DS] = 1'b1;
            PFX_FS:     seg_c[SEG_FS] = 1'b1;
            PFX_GS:     seg_c[SEG_GS] = 1'b1;
            default:    pfx_c = 1'b0;  // Not a prefix, every flag stays clear
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            info.raw_byte  <= '0;
            info.is_prefix <= 1'b0;
            info.is_rep    <= 1'b0;
            info.is_repne  <= 1'b0;
            info.seg       <= '0;
            info.is_opsize <= 1'b0;
        end else begin
            info.raw_byte  <= prefix;  // Kept so the merge stage can pick the opcode
            info.is_prefix <= pfx_c;
            info.is_rep    <= rep_c;
            info.is_repne  <= repne_c;
            info.seg       <= seg_c;
            info.is_opsize <= opsize_c;
        end
    end

endmodule

`default_nettype wire

//--- source/prefix_merge.sv
`timescale 1ns/1ns
`default_nettype none

module prefix_merge import prefix_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    prefix_info_if.consumer info [NUM_SLOTS],
    input  wire byte_t      tail_byte,
    input  wire logic       stage_valid,
    output prefix_count_t   num_prefixes,
    output logic            is_rep,
    output logic            is_repne,
    output seg_onehot_t     seg_override,
    output logic            is_opsize_override,
    output byte_t           opcode,
    output logic            decode_valid
);

    // Slot results unpacked into plain arrays
    logic [NUM_SLOTS-1:0] slot_pfx;
    logic [NUM_SLOTS-1:0] slot_rep;
    logic [NUM_SLOTS-1:0] slot_repne;
    logic [NUM_SLOTS-1:0] slot_opsize;
    seg_onehot_t          slot_seg [NUM_SLOTS];
    byte_t                slot_raw [NUM_SLOTS];

    // Merged values ahead of the output register
    logic          in_run;
    prefix_count_t count_c;
    logic          rep_c;
    logic          repne_c;
    logic          opsize_c;
    seg_onehot_t   seg_c;
    byte_t         opcode_c;

    for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_unpack
        assign slot_pfx[g]    = info[g].is_prefix;
        assign slot_rep[g]    = info[g].is_rep;
        assign slot_repne[g]  = info[g].is_repne;
        assign slot_opsize[g] = info[g].is_opsize;
        assign slot_seg[g]    = info[g].seg;
        assign slot_raw[g]    = info[g].raw_byte;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Leading run and flag merge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        in_run   = 1'b1;
        count_c  = '0;
        rep_c    = 1'b0;
        repne_c  = 1'b0;
        opsize_c = 1'b0;
        seg_c    = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            in_run = in_run & slot_pfx[i];  // Run ends at the first non-prefix byte
            if (in_run) begin
                count_c  = prefix_count_t'(i + 1);
                rep_c    = rep_c | slot_rep[i];
                repne_c  = repne_c | slot_repne[i];
                opsize_c = opsize_c | slot_opsize[i];
                if (slot_seg[i] != '0) begin
                    seg_c = slot_seg[i];  // Later override replaces an earlier one
                end
            end
        end
    end

    // Opcode is the first byte past the run
    always_comb begin
        opcode_c = tail_byte;  // All slots were prefixes
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (int'(count_c) == i) begin
                opcode_c = slot_raw[i];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            num_prefixes       <= '0;
            is_rep             <= 1'b0;
            is_repne           <= 1'b0;
            seg_override       <= '0;
            is_opsize_override <= 1'b0;
            opcode             <= '0;
            decode_valid       <= 1'b0;
        end else begin
            num_prefixes       <= count_c;
            is_rep             <= rep_c;
            is_repne           <= repne_c;
            seg_override       <= seg_c;
            is_opsize_override <= opsize_c;
            opcode             <= opcode_c;
            decode_valid       <= stage_valid;  // Lines up with the data of the same window
        end
    end

endmodule

`default_nettype wire

//--- source/prefix_decode.sv
`timescale 1ns/1ns
`default_nettype none

module prefix_decode import prefix_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic [PACKET_W-1:0] packet,
    input  wire logic                packet_valid,
    output prefix_count_t            num_prefixes,
    output logic                     is_rep,
    output logic                     is_repne,
    output seg_onehot_t              seg_override,
    output logic                     is_opsize_override,
    output byte_t                    opcode,
    output logic                     decode_valid
);

    byte_t slot_byte [NUM_SLOTS];  // Captured leading bytes
    byte_t tail_byte;              // Byte after the slots, delayed to the merge stage
    logic  stage_valid;

    prefix_info_if info [NUM_SLOTS] ();

    window_capture u_capture (
        .clk          (clk),
        .rst_n        (rst_n),
        .packet       (packet),
        .packet_valid (packet_valid),
        .slot_byte    (slot_byte),
        .tail_byte    (tail_byte),
        .stage_valid  (stage_valid)
    );

    // One lookup table per slot, all checked in parallel
    for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_lut
        prefix_lut u_lut (
            .clk    (clk),
            .rst_n  (rst_n),
            .prefix (slot_byte[g]),
            .info   (info[g])
        );
    end

    prefix_merge u_merge (
        .clk                (clk),
        .rst_n              (rst_n),
        .info               (info),
        .tail_byte          (tail_byte),
        .stage_valid        (stage_valid),
        .num_prefixes       (num_prefixes),
        .is_rep             (is_rep),
        .is_repne           (is_repne),
        .seg_override       (seg_override),
        .is_opsize_override (is_opsize_override),
        .opcode             (opcode),
        .decode_valid       (decode_valid)
    );

endmodule

`default_nettype wire

//--- testbench/prefix_decode_tb.sv
`timescale 1ns/1ns
`default_nettype none

module prefix_decode_tb import prefix_pkg::*; ();

    localparam int CLK_HALF     = 10;
    localparam int LATENCY      = 3;   // Capture, lookup and merge
    localparam int IDLE_CYCLES  = 3;   // Quiet cycles before the first and after the last window
    localparam int NUM_DIRECTED = 15;
    localparam int NUM_RANDOM   = 24;
    localparam int NUM_ROWS     = NUM_DIRECTED + NUM_RANDOM;

    typedef struct packed {
        logic [PACKET_W-1:0] packet;
        prefix_count_t       cnt;
        logic                rep;
        logic                repne;
        logic                opsize;
        seg_onehot_t         seg;
        byte_t               opc;
    } row_t;

    logic                clk = 1'b0;
    logic                rst_n;
    logic [PACKET_W-1:0] packet;
    logic                packet_valid;
    prefix_count_t       num_prefixes;
    logic                is_rep;
    logic                is_repne;
    seg_onehot_t         seg_override;
    logic                is_opsize_override;
    byte_t               opcode;
    logic                decode_valid;

    // Left aligned leading bytes of the directed rows and how many of them count
    logic [31:0] heads [NUM_DIRECTED] = '{
        32'h90000000, 32'hF2890000, 32'hF3A40000, 32'h66890000, 32'h268B0000,
        32'h2E8B0000, 32'h368B0000, 32'h3E8B0000, 32'h648B0000, 32'h658B0000,
        32'hF32E66A5, 32'h2E648B00, 32'h26363E89, 32'h90F3662E, 32'h660FF226
    };
    int head_len [NUM_DIRECTED] = '{1, 2, 2, 2, 2, 2, 2, 2, 2, 2, 4, 3, 4, 4, 4};

    byte_t pfx_list [9] = '{PFX_REPNE, PFX_REP, PFX_OPSIZE, PFX_ES, PFX_CS,
                            PFX_SS, PFX_DS, PFX_FS, PFX_GS};

    row_t table_rows [NUM_ROWS];
    row_t exp_q [$];     // Windows sent and not yet decoded
    int   strobe_q [$];  // Cycle of each strobe seen on the DUT input
    int   cycle = 0;
    row_t exp_row;

    prefix_decode UUT (
        .clk                (clk),
        .rst_n              (rst_n),
        .packet             (packet),
        .packet_valid       (packet_valid),
        .num_prefixes       (num_prefixes),
        .is_rep             (is_rep),
        .is_repne           (is_repne),
        .seg_override       (seg_override),
        .is_opsize_override (is_opsize_override),
        .opcode             (opcode),
        .decode_valid       (decode_valid)
    );

    always #CLK_HALF clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic seg_onehot_t seg_of(byte_t b);
        case (b)
            PFX_ES:  return seg_onehot_t'(1) << SEG_ES;
            PFX_CS:  return seg_onehot_t'(1) << SEG_CS;
            PFX_SS:  return seg_onehot_t'(1) << SEG_SS;
            PFX_DS:  return seg_onehot_t'(1) << SEG_DS;
            PFX_FS:  return seg_onehot_t'(1) << SEG_FS;
            PFX_GS:  return seg_onehot_t'(1) << SEG_GS;
            default: return '0;
        endcase
    endfunction

    function automatic logic known_prefix(byte_t b);
        return b inside {PFX_REPNE, PFX_REP, PFX_OPSIZE, PFX_ES, PFX_CS,
                         PFX_SS, PFX_DS, PFX_FS, PFX_GS};
    endfunction

    // Walks the leading run like an x86 decoder where the last segment override wins
    function automatic row_t with_expect(row_t r);
        byte_t b [4];
        int    n;
        for (int k = 0; k < 4; k++) begin
            b[k] = r.packet[PACKET_W - 1 - 8 * k -: 8];
        end
        n = 0;
        r.rep    = 1'b0;
        r.repne  = 1'b0;
        r.opsize = 1'b0;
        r.seg    = '0;
        while (n < NUM_SLOTS && known_prefix(b[n])) begin
            if (b[n] == PFX_REP) r.rep = 1'b1;
            if (b[n] == PFX_REPNE) r.repne = 1'b1;
            if (b[n] == PFX_OPSIZE) r.opsize = 1'b1;
            if (seg_of(b[n]) != '0) r.seg = seg_of(b[n]);
            n++;
        end
        r.cnt = prefix_count_t'(n);
        r.opc = b[n];
        return r;
    endfunction

    // Half the random bytes are prefixes so the runs get exercised
    function automatic byte_t random_byte();
        if ($urandom % 2 == 0) return pfx_list[$urandom % 9];
        return byte_t'($urandom);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic report_problem(string what);
        $display("Error at %0t ns: %s", $time, what);
        abort_run();
    endtask

    task automatic check_count(string name, prefix_count_t exp, prefix_count_t act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_seg(string name, seg_onehot_t exp, seg_onehot_t act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_byte(string name, byte_t exp, byte_t act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // Outputs are sampled on the falling edge half a cycle away from any change
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (packet_valid) strobe_q.push_back(cycle);
        if (decode_valid) begin
            if (strobe_q.size() == 0 || exp_q.size() == 0) begin
                report_problem("decode_valid is high with no window outstanding");
            end else if (cycle - strobe_q[0] != LATENCY) begin
                report_problem("decode_valid did not come three cycles after its strobe");
            end else begin
                exp_row = exp_q.pop_front();
                void'(strobe_q.pop_front());
                check_count("num_prefixes", exp_row.cnt, num_prefixes);
                check_flag("is_rep", exp_row.rep, is_rep);
                check_flag("is_repne", exp_row.repne, is_repne);
                check_flag("is_opsize_override", exp_row.opsize, is_opsize_override);
                check_seg("seg_override", exp_row.seg, seg_override);
                check_byte("opcode", exp_row.opc, opcode);
            end
        end else if (strobe_q.size() != 0 && cycle - strobe_q[0] >= LATENCY) begin
            report_problem("decode_valid never came for a window that was sent");
        end
    end

    // Watchdog
    initial begin
        #((NUM_ROWS + 2 * IDLE_CYCLES + 10) * 2 * CLK_HALF);
        $display("Error at %0t ns: the run timed out", $time);
        abort_run();
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        rst_n        = 1'b0;
        packet       = '0;
        packet_valid = 1'b0;
        void'($urandom(99));
        for (int r = 0; r < NUM_ROWS; r++) begin
            table_rows[r].packet = {$urandom, $urandom, $urandom, $urandom};
            for (int k = 0; k < 4; k++) begin
                if (r < NUM_DIRECTED && k < head_len[r]) begin
                    table_rows[r].packet[PACKET_W - 1 - 8 * k -: 8] = heads[r][31 - 8 * k -: 8];
                end else if (r >= NUM_DIRECTED) begin
                    table_rows[r].packet[PACKET_W - 1 - 8 * k -: 8] = random_byte();
                end
            end
            table_rows[r] = with_expect(table_rows[r]);
        end

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (IDLE_CYCLES) @(posedge clk);  // Out of reset with no strobe yet
        for (int r = 0; r < NUM_ROWS; r++) begin
            packet       <= table_rows[r].packet;  // One window per cycle
            packet_valid <= 1'b1;
            exp_q.push_back(table_rows[r]);
            @(posedge clk);
        end
        packet_valid <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (IDLE_CYCLES) @(posedge clk);  // Nothing more may follow the last window

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- prefix_decode.f
source/prefix_pkg.sv
source/prefix_info_if.sv
source/window_capture.sv
source/prefix_lut.sv
source/prefix_merge.sv
source/prefix_decode.sv
testbench/prefix_decode_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module prefix_decode_tb \
    -f prefix_decode.f -o prefix_decode_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/prefix_decode_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    exit 1
fi

exit 0
